//--- hdl/capture_pkg.sv
package capture_pkg;

   // Sensor sample and host bus widths
   localparam int PIXEL_W = 10;
   localparam int WORD_W  = 32;

   // Bus word is built from two halfwords
   localparam int HALF_W  = WORD_W / 2;

   // Counter widths
   localparam int ROW_COUNT_W = 10;
   localparam int COL_COUNT_W = 10;
   localparam int PIX_COUNT_W = 21;

   // Raw sample from the sensor
   typedef logic [PIXEL_W-1:0]     pixel_t;

   // Word as it enters the downstream FIFO
   typedef logic [WORD_W-1:0]      word_t;

   // One half of a bus word
   typedef logic [HALF_W-1:0]      half_t;

   // Counter types
   typedef logic [ROW_COUNT_W-1:0] row_count_t;
   typedef logic [COL_COUNT_W-1:0] col_count_t;
   typedef logic [PIX_COUNT_W-1:0] pix_count_t;

   // Row window, first line of the frame is row 1
   localparam row_count_t ROW_FIRST = row_count_t'(1);
   localparam row_count_t ROW_LAST  = row_count_t'(480);

   // Row counter parks here once past the window
   localparam row_count_t ROW_SAT   = ROW_LAST + row_count_t'(1);

   // Column window starts at the first pixel of a line
   // Counter parks at the limit
   localparam col_count_t ACTIVE_COLS = col_count_t'(640);

   // Frame write counter stops at all ones
   localparam pix_count_t PIX_COUNT_MAX = '1;

   // Padding between the sample and the top of its halfword
   localparam int PAD_W = HALF_W - PIXEL_W;

endpackage

//--- hdl/column_tracker.sv
`timescale 1ns/1ps

module column_tracker
(
   input  logic clk_80,
   input  logic FRAME_VALID,
   input  logic LINE_VALID,
   output logic col_active
);

   import capture_pkg::*;

   // Pixels already sampled in the current line
   col_count_t col_count;

   // Current sample still inside the column window
   logic       col_in_window;

   // Count before the increment decides the flag
   assign col_in_window = (col_count < ACTIVE_COLS);

   always_ff @(posedge clk_80 or negedge FRAME_VALID)
   begin
      if (!FRAME_VALID)
      begin
         col_count  <= '0;
         col_active <= 1'b0;
      end
      else if (!LINE_VALID)
      begin
         // Gap between lines
         // Next line starts again at column 0
         col_count  <= '0;
         col_active <= 1'b0;
      end
      else
      begin
         // Sample edge
         col_active <= col_in_window;
         // Saturate at the window width
         // Extra pixels of a long line leave the count alone
         if (col_in_window)
         begin
            col_count <= col_count + col_count_t'(1);
         end
      end
   end

endmodule

//--- hdl/line_tracker.sv
`timescale 1ns/1ps

module line_tracker
(
   input  logic clk_80,
   input  logic FRAME_VALID,
   input  logic LINE_VALID,
   output logic row_active
);

   import capture_pkg::*;

   // LINE_VALID from the previous edge
   logic       lv_prev;

   // High on the first sample of a line
   logic       line_start;

   // Lines seen so far in this frame
   row_count_t row_count;

   // Count including the line that starts now
   row_count_t row_next;

   // Updated count inside the row window
   logic       row_in_window;

   // Rising edge of LINE_VALID, seen on the clk_80 grid
   assign line_start = LINE_VALID & ~lv_prev;

   // Advance on each line start
   // Stop one past the last row so later lines stay outside
   always_comb
   begin
      row_next = row_count;
      if (line_start && (row_count != ROW_SAT))
      begin
         row_next = row_count + row_count_t'(1);
      end
   end

   // Rows 1 to 480 inclusive
   assign row_in_window = (row_next >= ROW_FIRST) && (row_next <= ROW_LAST);

   // FRAME_VALID low clears everything
   // Each frame starts again at row 0
   always_ff @(posedge clk_80 or negedge FRAME_VALID)
   begin
      if (!FRAME_VALID)
      begin
         lv_prev    <= 1'b0;
         row_count  <= '0;
         row_active <= 1'b0;
      end
      else
      begin
         lv_prev    <= LINE_VALID;
         row_count  <= row_next;
         // Flag for the pixel sampled at this edge
         // Low between lines
         row_active <= LINE_VALID & row_in_window;
      end
   end

endmodule

//--- hdl/pixel_writer.sv
`timescale 1ns/1ps

module pixel_writer
(
   input  logic                    clk_80,
   input  logic                    FRAME_VALID,
   input  capture_pkg::pixel_t     DATA_IMAGE,
   input  logic                    row_active,
   input  logic                    col_active,
   input  logic                    fifo_full,
   output logic                    fifo_wr_en,
   output capture_pkg::word_t      fifo_din,
   output capture_pkg::pix_count_t frame_pixels,
   output logic                    overflow
);

   import capture_pkg::*;

   // Sensor output is inverted
   pixel_t sample_inv;

   // Inverted sample zero-extended to a halfword
   half_t  sample_half;

   // Word after the halfword swap
   word_t  bus_word;

   assign sample_inv = ~DATA_IMAGE;

   assign sample_half = {{PAD_W{1'b0}}, sample_inv};

   // Host reads the halves in the other order
   // Sample lands in bits 25 to 16, low half stays zero
   assign bus_word = {sample_half, half_t'(0)};

   // Word register
   // Loaded on every edge, only meaningful with fifo_wr_en
   always_ff @(posedge clk_80)
   begin
      fifo_din <= bus_word;
   end

   // Both flags were registered at the same edge as fifo_din
   // Write lands one cycle after the sample
   assign fifo_wr_en = row_active & col_active;

   // Writes in this frame
   // Saturates instead of wrapping
   always_ff @(posedge clk_80 or negedge FRAME_VALID)
   begin
      if (!FRAME_VALID)
      begin
         frame_pixels <= '0;
      end
      else if (fifo_wr_en && (frame_pixels != PIX_COUNT_MAX))
      begin
         frame_pixels <= frame_pixels + pix_count_t'(1);
      end
   end

   // Sticky overflow
   // Any edge with the FIFO full, write or not
   // Writes are not held back, data may be lost downstream
   always_ff @(posedge clk_80 or negedge FRAME_VALID)
   begin
      if (!FRAME_VALID)
      begin
         overflow <= 1'b0;
      end
      else if (fifo_full)
      begin
         overflow <= 1'b1;
      end
   end

endmodule

//--- hdl/sensor_capture_top.sv
`timescale 1ns/1ps

module sensor_capture_top
(
   input  logic                    clk_80,
   input  logic                    FRAME_VALID,
   input  logic                    LINE_VALID,
   input  capture_pkg::pixel_t     DATA_IMAGE,
   input  logic                    fifo_full,
   output logic                    fifo_wr_en,
   output capture_pkg::word_t      fifo_din,
   output capture_pkg::pix_count_t frame_pixels,
   output logic                    overflow
);

   // Current pixel lies in rows 1 to 480
   logic row_active;

   // Current pixel lies in the first 640 columns
   logic col_active;

   // Row window from LINE_VALID rising edges
   line_tracker u_line_tracker
   (
      .clk_80      (clk_80),
      .FRAME_VALID (FRAME_VALID),
      .LINE_VALID  (LINE_VALID),
      .row_active  (row_active)
   );

   // Column window from the samples within a line
   column_tracker u_column_tracker
   (
      .clk_80      (clk_80),
      .FRAME_VALID (FRAME_VALID),
      .LINE_VALID  (LINE_VALID),
      .col_active  (col_active)
   );

   // FIFO write side, word format and frame statistics
   pixel_writer u_pixel_writer
   (
      .clk_80       (clk_80),
      .FRAME_VALID  (FRAME_VALID),
      .DATA_IMAGE   (DATA_IMAGE),
      .row_active   (row_active),
      .col_active   (col_active),
      .fifo_full    (fifo_full),
      .fifo_wr_en   (fifo_wr_en),
      .fifo_din     (fifo_din),
      .frame_pixels (frame_pixels),
      .overflow     (overflow)
   );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
   --top-module sensor_capture_tb \
   --Mdir obj_dir \
   -f sensor_capture.f

./obj_dir/Vsensor_capture_tb

//--- sensor_capture.f
hdl/capture_pkg.sv
hdl/line_tracker.sv
hdl/column_tracker.sv
hdl/pixel_writer.sv
hdl/sensor_capture_top.sv
verification/sensor_capture_checker.sv
verification/sensor_capture_tb.sv

//--- verification/sensor_capture_checker.sv
`timescale 1ns/1ps

module sensor_capture_checker
(
   input logic               clk_80,
   input logic               FRAME_VALID,
   input logic               fifo_wr_en,
   input capture_pkg::word_t fifo_din,
   input logic               overflow
);

   import capture_pkg::*;

   // No write strobe while the frame is held in reset
   wr_low_in_reset: assert property (
      @(posedge clk_80) !FRAME_VALID |-> !fifo_wr_en)
      else $error("fifo_wr_en high while FRAME_VALID is low");

   // Sticky flag, only a new frame clears it
   overflow_sticky: assert property (
      @(posedge clk_80) disable iff (!FRAME_VALID)
      ($past(FRAME_VALID) && $past(overflow)) |-> overflow)
      else $error("overflow fell while FRAME_VALID is high");

   // Sample sits in the upper half after the swap
   low_half_zero: assert property (
      @(posedge clk_80) fifo_wr_en |-> (fifo_din[HALF_W-1:0] == '0))
      else $error("low half of fifo_din not zero on a write");

endmodule

// Attached to every instance of the top level
bind sensor_capture_top sensor_capture_checker u_checker
(
   .clk_80      (clk_80),
   .FRAME_VALID (FRAME_VALID),
   .fifo_wr_en  (fifo_wr_en),
   .fifo_din    (fifo_din),
   .overflow    (overflow)
);

//--- verification/sensor_capture_tb.sv
`timescale 1ns/1ps

module sensor_capture_tb;

   // Stimulus shape
   localparam int RESET_CYCLES = 16;
   localparam int FRAME1_LINES = 482;
   localparam int SHORT_LEN    = 6;
   localparam int MAX_GAP      = 4;
   localparam int LONG_LEN     = 700;
   localparam int FRAME2_LINES = 6;
   localparam int FULL_LINE    = 100;
   localparam int EDGE_IDLE    = 4;
   localparam int RESTART_IDLE = 8;
   localparam int DRAIN_CYCLES = 4;

   // Worst case with every gap at its longest
   localparam int STIM_CYCLES = RESET_CYCLES + 4 * EDGE_IDLE + RESTART_IDLE
      + FRAME1_LINES * (SHORT_LEN + MAX_GAP) + (LONG_LEN + MAX_GAP)
      + (FRAME2_LINES - 1) * (SHORT_LEN + MAX_GAP) + DRAIN_CYCLES;

   // Twice the stimulus, about 11k cycles
   localparam int TIMEOUT_CYCLES = 2 * STIM_CYCLES;

   localparam logic [31:0] SEED = 32'h4113_1533;

   logic        clk_80;
   logic        FRAME_VALID;
   logic        LINE_VALID;
   logic [9:0]  DATA_IMAGE;
   logic        fifo_full;
   logic        fifo_wr_en;
   logic [31:0] fifo_din;
   logic [20:0] frame_pixels;
   logic        overflow;

   // Expected response per driven cycle, oldest first
   logic        exp_wr_q[$];
   logic [31:0] exp_word_q[$];

   // Entry under comparison
   logic        cmp_wr;
   logic [31:0] cmp_word;

   logic [31:0] rng_state;
   logic        full_level;
   int          frame_writes;
   int          cycle_count;
   int          line_no;

   sensor_capture_top uut
   (
      .clk_80       (clk_80),
      .FRAME_VALID  (FRAME_VALID),
      .LINE_VALID   (LINE_VALID),
      .DATA_IMAGE   (DATA_IMAGE),
      .fifo_full    (fifo_full),
      .fifo_wr_en   (fifo_wr_en),
      .fifo_din     (fifo_din),
      .frame_pixels (frame_pixels),
      .overflow     (overflow)
   );

   // 8 ns period
   initial
   begin
      clk_80 = 1'b0;
   end

   always #4 clk_80 = ~clk_80;

   task automatic abort_run(input string reason);
      $display("*** TEST FAILED ***");
      $fatal(1, "%s", reason);
   endtask

   task automatic compare_value(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
      if (actual !== expected)
      begin
         $display("ERR time=%0t signal=%s actual=0x%08h expected=0x%08h",
                  $time, name, actual, expected);
         abort_run($sformatf("%s differs from the model", name));
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] state);
      logic [31:0] x;
      x = state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   // Write decision in bit 32, bus word below
   // Rows counted from 1, columns from 0
   function automatic logic [32:0] expected_result(input int row, input int col,
                                                   input logic [9:0] pix);
      logic [15:0] half;
      logic [31:0] word;
      logic        wr;
      // Inverted sample, zero-extended
      half = {6'b0, ~pix};
      word = {16'h0000, half};
      wr   = (row >= 1) && (row <= 480) && (col < 640);
      // Halfwords swapped
      return {wr, word[15:0], word[31:16]};
   endfunction

   // One clock of stimulus, applied on the falling edge
   task automatic drive_cycle(input logic fv, input logic lv, input int row, input int col);
      logic [32:0] result;
      @(negedge clk_80);
      rng_state   = xorshift32(rng_state);
      FRAME_VALID = fv;
      LINE_VALID  = lv;
      DATA_IMAGE  = rng_state[9:0];
      fifo_full   = full_level;
      if (fv && lv)
      begin
         result = expected_result(row, col, rng_state[9:0]);
      end
      else
      begin
         // Gap or reset, nothing written
         result = '0;
      end
      exp_wr_q.push_back(result[32]);
      exp_word_q.push_back(result[31:0]);
      if (result[32])
      begin
         frame_writes++;
      end
   endtask

   task automatic drive_idle(input logic fv, input int count);
      repeat (count) drive_cycle(fv, 1'b0, 0, 0);
   endtask

   // Line of len pixels, then a random gap of 1 to MAX_GAP cycles
   task automatic drive_line(input int row, input int len);
      int col;
      int gap;
      for (col = 0; col < len; col++)
      begin
         drive_cycle(1'b1, 1'b1, row, col);
      end
      gap = int'(rng_state[1:0]) + 1;
      drive_idle(1'b1, gap);
   endtask

   // Outputs for the sample taken at this edge
   // Checked half a cycle later once settled
   always @(posedge clk_80)
   begin
      if (exp_wr_q.size() > 0)
      begin
         cmp_wr   = exp_wr_q.pop_front();
         cmp_word = exp_word_q.pop_front();
         @(negedge clk_80);
         compare_value("fifo_wr_en", 32'(fifo_wr_en), 32'(cmp_wr));
         if (cmp_wr)
         begin
            compare_value("fifo_din", fifo_din, cmp_word);
         end
      end
   end

   // Run limit
   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk_80);
         cycle_count++;
      end
      abort_run($sformatf("run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

   initial
   begin
      FRAME_VALID    = 1'b0;
      LINE_VALID     = 1'b0;
      DATA_IMAGE     = '0;
      fifo_full      = 1'b0;
      full_level     = 1'b0;
      rng_state      = SEED;
      frame_writes   = 0;

      // Power-up reset
      drive_idle(1'b0, RESET_CYCLES);

      // Frame 1, rows 481 and 482 fall outside
      frame_writes = 0;
      drive_idle(1'b1, EDGE_IDLE);
      for (line_no = 1; line_no <= FRAME1_LINES; line_no++)
      begin
         if (line_no == FULL_LINE)
         begin
            compare_value("overflow", 32'(overflow), 32'd0);
            full_level = 1'b1;
         end
         drive_line(line_no, SHORT_LEN);
         if (line_no == FULL_LINE)
         begin
            // FIFO full over one line and its gap
            full_level = 1'b0;
            compare_value("overflow", 32'(overflow), 32'd1);
         end
      end
      drive_idle(1'b1, EDGE_IDLE);
      compare_value("frame_pixels", 32'(frame_pixels), 32'(frame_writes));
      compare_value("overflow", 32'(overflow), 32'd1);

      // Frame boundary clears the statistics
      drive_idle(1'b0, RESTART_IDLE);
      compare_value("frame_pixels", 32'(frame_pixels), 32'd0);
      compare_value("overflow", 32'(overflow), 32'd0);

      // Frame 2, long first line hits the column limit
      frame_writes = 0;
      drive_idle(1'b1, EDGE_IDLE);
      drive_line(1, LONG_LEN);
      for (line_no = 2; line_no <= FRAME2_LINES; line_no++)
      begin
         drive_line(line_no, SHORT_LEN);
      end
      drive_idle(1'b1, EDGE_IDLE);
      compare_value("frame_pixels", 32'(frame_pixels), 32'(frame_writes));
      compare_value("overflow", 32'(overflow), 32'd0);

      drive_idle(1'b1, DRAIN_CYCLES);

      // Last queued samples still go through the comparison
      while (exp_wr_q.size() > 0)
      begin
         @(posedge clk_80);
      end
      @(posedge clk_80);

      $display("*** TEST PASSED ***");
      $finish;
   end

endmodule
